// ==== source/pokerPkg.sv ====
`default_nettype none

package pokerPkg;

	// card field widths
	localparam int suitWidth = 2;
	localparam int rankWidth = 4;

	// cards per hand
	localparam int handSize = 5;

	// width of the hand type code
	localparam int handTypeWidth = 4;

	// enough bits to count matches up to a full hand
	localparam int countWidth = $clog2(handSize + 1);

	typedef logic [suitWidth-1:0] suitT;
	typedef logic [rankWidth-1:0] rankT;
	typedef logic [countWidth-1:0] countT;

	// ace counts as 1 and king is the top legal rank
	localparam rankT aceRank = rankT'(1);
	localparam rankT tenRank = rankT'(10);
	localparam rankT kingRank = rankT'(13);

	// suit sits above rank in a 6-bit card
	typedef struct packed {
		suitT suit;
		rankT rank;
	} cardT;

	// card 0 in the low bits
	typedef cardT [handSize-1:0] handT;

	// one-hot summary of how the ranks repeat
	typedef struct packed {
		logic fourOfAKind;
		logic fullHouse;
		logic threeOfAKind;
		logic twoPairs;
		logic onePair;
		logic distinctRanks;
	} rankPatternT;

	// hand type codes, weakest hand lowest
	typedef enum logic [handTypeWidth-1:0] {
		highCard = 4'd0,
		onePairHand = 4'd1,
		twoPairsHand = 4'd2,
		threeHand = 4'd3,
		straightHand = 4'd4,
		flushHand = 4'd5,
		fullHouseHand = 4'd6,
		fourHand = 4'd7,
		straightFlushHand = 4'd8
	} handTypeT;

endpackage

`default_nettype wire

// ==== source/pokerRankMatcher.sv ====
`timescale 1ns/10ps
`default_nettype none

module pokerRankMatcher (
	input  pokerPkg::handT        hand,
	output pokerPkg::rankPatternT rankPattern
);

	// sameRank[i][j] high when cards i and j share a rank
	// diagonal stays low
	logic [pokerPkg::handSize-1:0][pokerPkg::handSize-1:0] sameRank;

	// other cards with the same rank, per card
	// multiplicity of that rank is matchCount + 1
	pokerPkg::countT [pokerPkg::handSize-1:0] matchCount;

	// some card sees three or four partners
	logic anyFour;
	// some card sees exactly two partners
	logic anyThree;
	// number of cards sitting in a plain pair
	pokerPkg::countT pairCards;

	// ten comparisons, mirrored into the full matrix
	always_comb begin
		sameRank = '0;
		for (int i = 0; i < pokerPkg::handSize; i++) begin
			for (int j = i + 1; j < pokerPkg::handSize; j++) begin
				sameRank[i][j] = (hand[i].rank == hand[j].rank);
				sameRank[j][i] = sameRank[i][j];
			end
		end
	end

	// row sums of the matrix
	always_comb begin
		for (int i = 0; i < pokerPkg::handSize; i++) begin
			matchCount[i] = '0;
			for (int j = 0; j < pokerPkg::handSize; j++) begin
				matchCount[i] = matchCount[i] + pokerPkg::countT'(sameRank[i][j]);
			end
		end
	end

	// fold per-card multiplicities into a few flags
	always_comb begin
		anyFour = 1'b0;
		anyThree = 1'b0;
		pairCards = '0;
		for (int i = 0; i < pokerPkg::handSize; i++) begin
			// five of a kind lands here too
			if (matchCount[i] >= pokerPkg::countT'(3))
				anyFour = 1'b1;
			if (matchCount[i] == pokerPkg::countT'(2))
				anyThree = 1'b1;
			if (matchCount[i] == pokerPkg::countT'(1))
				pairCards = pairCards + pokerPkg::countT'(1);
		end
	end

	// pair cards come in twos, so 0, 2 or 4
	// every legal combination maps to exactly one flag
	always_comb begin
		rankPattern = '0;
		rankPattern.fourOfAKind = anyFour;
		rankPattern.fullHouse = anyThree && (pairCards == pokerPkg::countT'(2));
		rankPattern.threeOfAKind = anyThree && (pairCards == '0);
		rankPattern.twoPairs = (pairCards == pokerPkg::countT'(4));
		rankPattern.onePair = !anyThree && (pairCards == pokerPkg::countT'(2));
		// nothing repeats at all
		rankPattern.distinctRanks = !anyFour && !anyThree && (pairCards == '0);
	end

endmodule

`default_nettype wire

// ==== source/pokerStraightFlushDetector.sv ====
`timescale 1ns/10ps
`default_nettype none

module pokerStraightFlushDetector (
	input  pokerPkg::handT hand,
	input  logic           distinctRanks,
	output logic           straight,
	output logic           flush
);

	// smallest and largest rank in the hand
	pokerPkg::rankT minRank;
	pokerPkg::rankT maxRank;

	// one bit per rank value present in the hand
	logic [(1 << pokerPkg::rankWidth)-1:0] rankSeen;

	// five ranks in a row with the ace low
	logic lowRun;
	// 10 J Q K A
	logic aceHighRun;

	// all suits equal to card 0
	always_comb begin
		flush = 1'b1;
		for (int i = 1; i < pokerPkg::handSize; i++) begin
			if (hand[i].suit != hand[0].suit)
				flush = 1'b0;
		end
	end

	// linear min/max scan
	always_comb begin
		minRank = hand[0].rank;
		maxRank = hand[0].rank;
		for (int i = 1; i < pokerPkg::handSize; i++) begin
			if (hand[i].rank < minRank)
				minRank = hand[i].rank;
			if (hand[i].rank > maxRank)
				maxRank = hand[i].rank;
		end
	end

	// rank presence map
	always_comb begin
		rankSeen = '0;
		for (int i = 0; i < pokerPkg::handSize; i++) begin
			rankSeen[hand[i].rank] = 1'b1;
		end
	end

	// distinct ranks spanning four steps are consecutive
	// A-2-3-4-5 falls out here since the ace is rank 1
	assign lowRun = ((maxRank - minRank) == pokerPkg::rankT'(pokerPkg::handSize - 1));

	// ace taken high, needs the ace plus ten through king
	assign aceHighRun = rankSeen[pokerPkg::aceRank]
		&& (&rankSeen[pokerPkg::kingRank:pokerPkg::tenRank]);

	// repeats rule out a straight
	// the distinct check comes from the rank matcher
	assign straight = distinctRanks && (lowRun || aceHighRun);

endmodule

`default_nettype wire

// ==== source/pokerHandRanker.sv ====
`timescale 1ns/10ps
`default_nettype none

module pokerHandRanker (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  inValid,
	input  pokerPkg::rankPatternT rankPattern,
	input  logic                  straight,
	input  logic                  flush,
	output logic                  outValid,
	output pokerPkg::handTypeT    handType
);

	// hand features held between the two stages
	typedef struct packed {
		pokerPkg::rankPatternT rankPattern;
		logic straight;
		logic flush;
	} featureT;

	// stage one
	logic stageValid;
	featureT stageFeatures;

	// priority encoder output feeding stage two
	pokerPkg::handTypeT nextType;

	// valid bit of stage one
	always_ff @(posedge clk) begin
		if (!rstN)
			stageValid <= 1'b0;
		else
			stageValid <= inValid;
	end

	// features captured only on a strobed hand
	always_ff @(posedge clk) begin
		if (inValid)
			stageFeatures <= '{rankPattern: rankPattern, straight: straight, flush: flush};
	end

	// best hand wins
	// four of a kind and full house beat flush and straight
	always_comb begin
		if (stageFeatures.straight && stageFeatures.flush)
			nextType = pokerPkg::straightFlushHand;
		else if (stageFeatures.rankPattern.fourOfAKind)
			nextType = pokerPkg::fourHand;
		else if (stageFeatures.rankPattern.fullHouse)
			nextType = pokerPkg::fullHouseHand;
		else if (stageFeatures.flush)
			nextType = pokerPkg::flushHand;
		else if (stageFeatures.straight)
			nextType = pokerPkg::straightHand;
		else if (stageFeatures.rankPattern.threeOfAKind)
			nextType = pokerPkg::threeHand;
		else if (stageFeatures.rankPattern.twoPairs)
			nextType = pokerPkg::twoPairsHand;
		else if (stageFeatures.rankPattern.onePair)
			nextType = pokerPkg::onePairHand;
		else
			nextType = pokerPkg::highCard;
	end

	// stage two holds the code until the next valid hand
	always_ff @(posedge clk) begin
		if (!rstN) begin
			outValid <= 1'b0;
			handType <= pokerPkg::highCard;
		end else begin
			outValid <= stageValid;
			if (stageValid)
				handType <= nextType;
		end
	end

	// matcher must hand over exactly one pattern flag per hand
	patternOneHot: assert property (
		@(posedge clk) disable iff (!rstN)
		stageValid |-> $onehot(stageFeatures.rankPattern)
	) else $error("rank pattern not one-hot in stage one");

	// no result without a strobe two edges earlier
	outValidFromStrobe: assert property (
		@(posedge clk) disable iff (!rstN)
		outValid |-> $past(inValid, 2)
	) else $error("outValid without matching inValid");

endmodule

`default_nettype wire

// ==== source/poker.sv ====
`timescale 1ns/10ps
`default_nettype none

module poker (
	input  logic               clk,
	input  logic               rstN,
	input  logic               inValid,
	input  pokerPkg::handT     hand,
	output logic               outValid,
	output pokerPkg::handTypeT handType
);

	// combinational features of the incoming hand
	pokerPkg::rankPatternT rankPattern;
	logic straight;
	logic flush;

	// per card, rank inside ace..king
	logic [pokerPkg::handSize-1:0] rankLegal;

	// repeats of ranks
	pokerRankMatcher u_rankMatcher (
		.hand        (hand),
		.rankPattern (rankPattern)
	);

	// suits and runs, reusing the matcher's distinct check
	pokerStraightFlushDetector u_straightFlushDetector (
		.hand          (hand),
		.distinctRanks (rankPattern.distinctRanks),
		.straight      (straight),
		.flush         (flush)
	);

	// two register stages and the priority encoder
	pokerHandRanker u_handRanker (
		.clk         (clk),
		.rstN        (rstN),
		.inValid     (inValid),
		.rankPattern (rankPattern),
		.straight    (straight),
		.flush       (flush),
		.outValid    (outValid),
		.handType    (handType)
	);

	for (genvar i = 0; i < pokerPkg::handSize; i++) begin : gRankLegal
		assign rankLegal[i] = (hand[i].rank >= pokerPkg::aceRank)
			&& (hand[i].rank <= pokerPkg::kingRank);
	end

	// ranks 0, 14 and 15 would fool the run detection
	legalRanks: assert property (
		@(posedge clk) disable iff (!rstN)
		inValid |-> (&rankLegal)
	) else $error("strobed hand holds an illegal rank");

endmodule

`default_nettype wire

// ==== bench/pokerClockGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module pokerClockGen #(
	parameter int periodNs = 4,
	parameter int resetCycles = 16
) (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		forever #(periodNs / 2.0) clk = ~clk;
	end

	// release just after a rising edge, like every other input
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#1 rstN = 1'b1;
	end

endmodule

`default_nettype wire

// ==== bench/pokerTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module pokerTb;

	localparam int clkPeriod = 4;
	localparam int directedCount = 15;
	localparam int randomCount = 2000;
	localparam int burstCount = 32;
	localparam int gapCount = 20;
	localparam int resetHands = 7;
	localparam int totalHands = directedCount + randomCount + burstCount + gapCount + resetHands;
	// covers reset, gaps and the drain after each test
	localparam int marginCycles = 512;
	localparam int watchdogNs = (totalHands + marginCycles) * clkPeriod;
	localparam int drainLimit = 8;

	// one expected result and the cycle it is due in
	typedef struct packed {
		pokerPkg::handTypeT code;
		logic [31:0] dueCycle;
	} expectT;

	logic clk;
	logic genRstN;
	logic midRstN;
	logic dutRstN;
	logic inValid;
	pokerPkg::handT hand;
	logic outValid;
	pokerPkg::handTypeT handType;

	expectT expQ[$];
	expectT head;
	pokerPkg::handT dirHand[$];
	pokerPkg::handTypeT dirCode[$];
	int cycleCount = 0;
	logic rstSampled;
	int checkCount = 0;
	int failCount = 0;
	logic [15:0] lfsrState = 16'd37;

	pokerClockGen #(
		.periodNs    (clkPeriod),
		.resetCycles (16)
	) u_clockGen (
		.clk  (clk),
		.rstN (genRstN)
	);

	// power-on reset or the mid-stream one
	assign dutRstN = genRstN && midRstN;

	poker u_poker (
		.clk      (clk),
		.rstN     (dutRstN),
		.inValid  (inValid),
		.hand     (hand),
		.outValid (outValid),
		.handType (handType)
	);

	// 16-bit Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] state);
		if (state[0])
			return (state >> 1) ^ 16'hB400;
		return state >> 1;
	endfunction

	// one LFSR step per bit taken
	function automatic int randomBits(input int count);
		int value;
		value = 0;
		for (int i = 0; i < count; i++) begin
			value = (value << 1) | int'(lfsrState[0]);
			lfsrState = lfsrNext(lfsrState);
		end
		return value;
	endfunction

	// ranks redrawn until legal
	// repeated cards allowed
	function automatic pokerPkg::handT randomHand();
		pokerPkg::handT h;
		int r;
		for (int i = 0; i < pokerPkg::handSize; i++) begin
			do
				r = randomBits(4);
			while (r < 1 || r > 13);
			h[i].rank = pokerPkg::rankT'(r);
			h[i].suit = pokerPkg::suitT'(randomBits(2));
		end
		return h;
	endfunction

	// expected type from rank counts per value
	function automatic pokerPkg::handTypeT pokerClassify(input pokerPkg::handT h);
		int rankCount[16];
		int pairs;
		int threes;
		int fours;
		int lowest;
		int highest;
		logic sameSuit;
		logic run;
		foreach (rankCount[r])
			rankCount[r] = 0;
		pairs = 0;
		threes = 0;
		fours = 0;
		lowest = 15;
		highest = 0;
		sameSuit = 1'b1;
		for (int i = 0; i < pokerPkg::handSize; i++) begin
			rankCount[h[i].rank]++;
			if (h[i].suit != h[0].suit)
				sameSuit = 1'b0;
			if (int'(h[i].rank) < lowest)
				lowest = int'(h[i].rank);
			if (int'(h[i].rank) > highest)
				highest = int'(h[i].rank);
		end
		foreach (rankCount[r]) begin
			if (rankCount[r] == 2)
				pairs++;
			if (rankCount[r] == 3)
				threes++;
			if (rankCount[r] >= 4)
				fours++;
		end
		// five distinct ranks in a row with the ace low or above the king
		run = (pairs == 0) && (threes == 0) && (fours == 0)
			&& ((highest - lowest == 4) || (rankCount[1] == 1 && rankCount[10] == 1
			&& rankCount[11] == 1 && rankCount[12] == 1 && rankCount[13] == 1));
		if (run && sameSuit)
			return pokerPkg::straightFlushHand;
		if (fours > 0)
			return pokerPkg::fourHand;
		if (threes == 1 && pairs == 1)
			return pokerPkg::fullHouseHand;
		if (sameSuit)
			return pokerPkg::flushHand;
		if (run)
			return pokerPkg::straightHand;
		if (threes == 1)
			return pokerPkg::threeHand;
		if (pairs == 2)
			return pokerPkg::twoPairsHand;
		if (pairs == 1)
			return pokerPkg::onePairHand;
		return pokerPkg::highCard;
	endfunction

	// one nibble per card, card 0 in the low nibble
	task automatic addDirected(input pokerPkg::handTypeT code, input logic [19:0] ranks,
		input logic [19:0] suits);
		pokerPkg::handT h;
		for (int i = 0; i < pokerPkg::handSize; i++) begin
			h[i].rank = ranks[4*i +: 4];
			h[i].suit = suits[4*i +: 2];
		end
		dirHand.push_back(h);
		dirCode.push_back(code);
	endtask

	task automatic loadDirected();
		addDirected(pokerPkg::highCard, 20'h2579D, 20'h01230);
		addDirected(pokerPkg::onePairHand, 20'h338AC, 20'h01201);
		addDirected(pokerPkg::twoPairsHand, 20'h44991, 20'h10320);
		addDirected(pokerPkg::threeHand, 20'h7772B, 20'h01233);
		// ace low, ace high, middle
		addDirected(pokerPkg::straightHand, 20'h12345, 20'h01230);
		addDirected(pokerPkg::straightHand, 20'hABCD1, 20'h20131);
		addDirected(pokerPkg::straightHand, 20'h6789A, 20'h33320);
		addDirected(pokerPkg::flushHand, 20'h269BD, 20'h22222);
		// flush beats the pair
		addDirected(pokerPkg::flushHand, 20'h3379C, 20'h11111);
		addDirected(pokerPkg::fullHouseHand, 20'h88855, 20'h01230);
		addDirected(pokerPkg::fourHand, 20'hCCCC3, 20'h01232);
		// five of one rank
		addDirected(pokerPkg::fourHand, 20'h66666, 20'h01230);
		addDirected(pokerPkg::straightFlushHand, 20'hABCD1, 20'h33333);
		addDirected(pokerPkg::straightFlushHand, 20'h12345, 20'h00000);
		// Q K A 2 3 does not wrap
		addDirected(pokerPkg::highCard, 20'hCD123, 20'h01201);
	endtask

	// result due at the second edge after the drive edge
	task automatic sendHand(input pokerPkg::handT h, input pokerPkg::handTypeT code);
		@(posedge clk);
		#1;
		inValid = 1'b1;
		hand = h;
		expQ.push_back('{code: code, dueCycle: cycleCount + 2});
	endtask

	task automatic idleCycles(input int count);
		repeat (count) begin
			@(posedge clk);
			#1;
			inValid = 1'b0;
		end
	endtask

	// the hand strobed into the first reset edge must be dropped
	task automatic applyReset(input int cycles, input pokerPkg::handT h);
		@(posedge clk);
		#1;
		inValid = 1'b1;
		hand = h;
		midRstN = 1'b0;
		@(posedge clk);
		#1;
		inValid = 1'b0;
		repeat (cycles - 1) @(posedge clk);
		#1;
		midRstN = 1'b1;
	endtask

	// bounded wait for every pending result
	task automatic drainPipeline();
		int waited;
		waited = 0;
		idleCycles(1);
		while (expQ.size() != 0 && waited < drainLimit) begin
			@(posedge clk);
			waited++;
		end
		if (expQ.size() != 0) begin
			$display("%0d hands still had no result %0d cycles after the last strobe",
				expQ.size(), waited);
			failCount++;
			expQ.delete();
		end
	endtask

	task automatic finishTest(input int index, input string name, input int checksBefore,
		input int failsBefore);
		drainPipeline();
		$display("test %0d (%s) done: %0d checks, %0d failed", index, name,
			checkCount - checksBefore, failCount - failsBefore);
	endtask

	// cycle count and reset as seen by the DUT at each edge
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		rstSampled <= dutRstN;
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (cycleCount > 0) begin
			if (!rstSampled) begin
				checkCount++;
				if (outValid !== 1'b0) begin
					$display("FAILED at %0t: outValid expected 0 got %b in reset", $time,
						outValid);
					failCount++;
				end
				if (handType !== pokerPkg::highCard) begin
					$display("FAILED at %0t: handType expected %0d got %0d in reset", $time,
						pokerPkg::highCard, handType);
					failCount++;
				end
				// hands in flight are lost
				expQ.delete();
			end else if (outValid === 1'b1) begin
				if (expQ.size() == 0) begin
					$display("outValid rose at %0t with no hand pending", $time);
					failCount++;
				end else begin
					head = expQ.pop_front();
					checkCount++;
					if (head.dueCycle != cycleCount) begin
						$display("FAILED at %0t: outValid cycle expected %0d got %0d", $time,
							head.dueCycle, cycleCount);
						failCount++;
					end
					if (handType !== head.code) begin
						$display("FAILED at %0t: handType expected %0d got %0d", $time,
							head.code, handType);
						failCount++;
					end
				end
			end else if (outValid !== 1'b0) begin
				$display("outValid is unknown at %0t", $time);
				failCount++;
			end else if (expQ.size() != 0 && expQ[0].dueCycle < cycleCount) begin
				$display("no outValid at %0t for the hand due in cycle %0d", $time,
					expQ[0].dueCycle);
				failCount++;
				head = expQ.pop_front();
			end
		end
	end

	initial begin
		#(watchdogNs);
		$display("watchdog expired after %0d ns, the run did not finish", watchdogNs);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		int checksBefore;
		int failsBefore;
		pokerPkg::handT h;
		inValid = 1'b0;
		hand = '0;
		midRstN = 1'b1;
		loadDirected();
		wait (genRstN === 1'b1);

		// one hand per code and the edge cases
		checksBefore = checkCount;
		failsBefore = failCount;
		for (int i = 0; i < directedCount; i++) begin
			if (pokerClassify(dirHand[i]) != dirCode[i]) begin
				$display("reference classifier disagrees with directed hand %0d", i);
				failCount++;
			end
			sendHand(dirHand[i], dirCode[i]);
		end
		finishTest(1, "directed hands", checksBefore, failsBefore);

		checksBefore = checkCount;
		failsBefore = failCount;
		for (int i = 0; i < randomCount; i++) begin
			h = randomHand();
			sendHand(h, pokerClassify(h));
		end
		finishTest(2, "random hands", checksBefore, failsBefore);

		// back to back through every directed hand
		checksBefore = checkCount;
		failsBefore = failCount;
		for (int i = 0; i < burstCount; i++)
			sendHand(dirHand[i % directedCount], dirCode[i % directedCount]);
		finishTest(3, "consecutive hands", checksBefore, failsBefore);

		// idle gaps of one to four cycles
		checksBefore = checkCount;
		failsBefore = failCount;
		for (int i = 0; i < gapCount; i++) begin
			h = randomHand();
			sendHand(h, pokerClassify(h));
			idleCycles(1 + randomBits(2));
		end
		finishTest(4, "strobes with gaps", checksBefore, failsBefore);

		// one hand leaves before reset and one is caught in flight
		// a third is strobed into the reset edge and four follow it
		checksBefore = checkCount;
		failsBefore = failCount;
		for (int i = 0; i < 2; i++)
			sendHand(dirHand[i + 6], dirCode[i + 6]);
		applyReset(3, dirHand[8]);
		idleCycles(6);
		for (int i = 0; i < 4; i++) begin
			h = randomHand();
			sendHand(h, pokerClassify(h));
		end
		finishTest(5, "reset mid-stream", checksBefore, failsBefore);

		$display("%0d checks, %0d passed, %0d failed", checkCount, checkCount - failCount,
			failCount);
		if (failCount == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== poker.f ====
source/pokerPkg.sv
source/pokerRankMatcher.sv
source/pokerStraightFlushDetector.sv
source/pokerHandRanker.sv
source/poker.sv
bench/pokerClockGen.sv
bench/pokerTb.sv

// ==== Makefile ====
SIM       ?= verilator
TOP       ?= pokerTb
RTL_TOP   ?= poker
FILELIST  ?= poker.f
OBJDIR    ?= obj_dir
LINTFLAGS ?= --lint-only -Wall --timing
SIMFLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(SIM) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

# the run passes only if the pass line shows up in the output
sim: build
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJDIR)
